// ==== Bender.yml ====
package:
  name: cpu

sources:
  # package first, then the units, then the top level
  - design/cpu_pkg.sv
  - design/fetch_unit.sv
  - design/inst_queue.sv
  - design/exec_unit.sv
  - design/reg_file.sv
  - design/data_ram.sv
  - design/cpu_top.sv
  - target: simulation
    files:
      - verification/cpu_tb.sv

// ==== design/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // datapath
  localparam int xlen = 32;  // data and instruction width

  // register file
  localparam int reg_aw = 4;  // register index width
  localparam int num_regs = 16;  // x0..x15, x0 hardwired to zero

  // program rom
  localparam int imem_aw = 6;  // rom word address width
  localparam int imem_depth = 64;  // rom words

  // data memory, word addressed
  localparam int dmem_aw = 6;  // data word address width
  localparam int dmem_depth = 64;  // data words

  // instruction queue between fetch and execute
  localparam int queue_aw = 2;  // pointer width
  localparam int queue_depth = 4;  // entries

  // instruction word layout
  //   imm[31:20] rs2[19:16] rs1[15:12] rd[11:8] opt[7:4] opcode[3:0]
  localparam int imm_lsb = 20;  // sign extended immediate
  localparam int rs2_lsb = 16;  // second source
  localparam int rs1_lsb = 12;  // first source
  localparam int rd_lsb = 8;  // destination
  localparam int op_lsb = 0;  // opcode
  localparam int imm_w = 12;  // immediate width
  localparam int op_w = 4;  // opcode width

  // opcodes, anything else executes as a no-op
  localparam logic [op_w-1:0] op_addi = 4'h0;  // rd = rs1 + imm
  localparam logic [op_w-1:0] op_add = 4'h1;  // rd = rs1 + rs2
  localparam logic [op_w-1:0] op_lw = 4'h4;  // rd = mem[rs1 + imm]
  localparam logic [op_w-1:0] op_sw = 4'h5;  // mem[rs1 + imm] = rs2
  localparam logic [op_w-1:0] op_halt = 4'hA;  // stop and raise halted

endpackage

`default_nettype wire

// ==== design/cpu_top.sv ====
`default_nettype none

module cpu_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // program load
  input  logic                        prog_we,
  input  logic [cpu_pkg::imem_aw-1:0] prog_addr,
  input  logic [cpu_pkg::xlen-1:0]    prog_data,
  // debug reads
  input  logic [cpu_pkg::reg_aw-1:0]  dbg_reg_idx,
  output logic [cpu_pkg::xlen-1:0]    dbg_reg_data,
  input  logic [cpu_pkg::dmem_aw-1:0] dbg_mem_addr,
  output logic [cpu_pkg::xlen-1:0]    dbg_mem_data,
  // status
  output logic                        halted
);

  // fetch to queue
  logic                        push_en;
  logic [cpu_pkg::xlen-1:0]    push_word;
  logic                        full;

  // queue to execute
  logic                        pop_en;
  logic [cpu_pkg::xlen-1:0]    head_word;
  logic                        empty;

  // execute to register file
  logic [cpu_pkg::reg_aw-1:0]  rs1_idx;
  logic [cpu_pkg::reg_aw-1:0]  rs2_idx;
  logic [cpu_pkg::xlen-1:0]    rs1_val;
  logic [cpu_pkg::xlen-1:0]    rs2_val;
  logic                        wr_en;
  logic [cpu_pkg::reg_aw-1:0]  wr_idx;
  logic [cpu_pkg::xlen-1:0]    wr_data;

  // execute to data memory
  logic [cpu_pkg::dmem_aw-1:0] mem_addr;
  logic                        mem_we;
  logic [cpu_pkg::xlen-1:0]    mem_wdata;
  logic [cpu_pkg::xlen-1:0]    mem_rdata;

  fetch_unit u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .full      (full),
    .push_en   (push_en),
    .push_word (push_word)
  );

  inst_queue u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_en   (push_en),
    .push_word (push_word),
    .full      (full),
    .pop_en    (pop_en),
    .head_word (head_word),
    .empty     (empty)
  );

  exec_unit u_exec (
    .clk, .rst_n, .head_word, .empty, .pop_en,
    .rs1_idx, .rs2_idx, .rs1_val, .rs2_val,
    .wr_en, .wr_idx, .wr_data,
    .mem_addr, .mem_we, .mem_wdata, .mem_rdata,
    .halted
  );

  reg_file u_regs (
    .clk, .rst_n, .rs1_idx, .rs2_idx, .rs1_val, .rs2_val,
    .wr_en, .wr_idx, .wr_data, .dbg_reg_idx, .dbg_reg_data
  );

  data_ram u_dmem (
    .clk, .mem_addr, .mem_we, .mem_wdata, .mem_rdata,
    .dbg_mem_addr, .dbg_mem_data
  );

endmodule

`default_nettype wire

// ==== design/data_ram.sv ====
`default_nettype none

module data_ram (
  input  logic                        clk,
  // execute port
  input  logic [cpu_pkg::dmem_aw-1:0] mem_addr,
  input  logic                        mem_we,
  input  logic [cpu_pkg::xlen-1:0]    mem_wdata,
  output logic [cpu_pkg::xlen-1:0]    mem_rdata,
  // debug port, read only
  input  logic [cpu_pkg::dmem_aw-1:0] dbg_mem_addr,
  output logic [cpu_pkg::xlen-1:0]    dbg_mem_data
);

  logic [cpu_pkg::xlen-1:0] mem [cpu_pkg::dmem_depth];  // word array, contents survive reset

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;  // store lands at the edge
    end
  end

  assign mem_rdata = mem[mem_addr];  // async read for lw
  assign dbg_mem_data = mem[dbg_mem_addr];  // async read for the bench

  // store then load of the same word on the next cycle sees the new data
  a_store_load: assert property (
    @(posedge clk)
    mem_we ##1 (mem_addr == $past(mem_addr)) |-> mem_rdata == $past(mem_wdata)
  ) else $error("stored word not read back");

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
`default_nettype none

module exec_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  // queue side
  input  logic [cpu_pkg::xlen-1:0]    head_word,
  input  logic                        empty,
  output logic                        pop_en,
  // register file read
  output logic [cpu_pkg::reg_aw-1:0]  rs1_idx,
  output logic [cpu_pkg::reg_aw-1:0]  rs2_idx,
  input  logic [cpu_pkg::xlen-1:0]    rs1_val,
  input  logic [cpu_pkg::xlen-1:0]    rs2_val,
  // register file write
  output logic                        wr_en,
  output logic [cpu_pkg::reg_aw-1:0]  wr_idx,
  output logic [cpu_pkg::xlen-1:0]    wr_data,
  // data memory
  output logic [cpu_pkg::dmem_aw-1:0] mem_addr,
  output logic                        mem_we,
  output logic [cpu_pkg::xlen-1:0]    mem_wdata,
  input  logic [cpu_pkg::xlen-1:0]    mem_rdata,
  // status
  output logic                        halted
);

  logic [cpu_pkg::op_w-1:0]  op;  // opcode field
  logic [cpu_pkg::imm_w-1:0] imm;  // raw immediate field
  logic [cpu_pkg::xlen-1:0]  imm_ext;  // sign extended immediate
  logic [cpu_pkg::xlen-1:0]  operand_b;  // second adder input
  logic [cpu_pkg::xlen-1:0]  sum;  // alu result or effective address
  logic                      is_load;  // lw at head
  logic                      halt_now;  // halt retiring this cycle

  // field slicing
  assign op = head_word[cpu_pkg::op_lsb +: cpu_pkg::op_w];
  assign imm = head_word[cpu_pkg::imm_lsb +: cpu_pkg::imm_w];
  assign rs1_idx = head_word[cpu_pkg::rs1_lsb +: cpu_pkg::reg_aw];
  assign rs2_idx = head_word[cpu_pkg::rs2_lsb +: cpu_pkg::reg_aw];
  assign wr_idx = head_word[cpu_pkg::rd_lsb +: cpu_pkg::reg_aw];  // rd

  assign imm_ext = {{(cpu_pkg::xlen - cpu_pkg::imm_w){imm[cpu_pkg::imm_w-1]}}, imm};

  // one adder serves add, addi and the lw/sw address
  assign operand_b = (op == cpu_pkg::op_add) ? rs2_val : imm_ext;
  assign sum = rs1_val + operand_b;

  assign mem_addr = sum[cpu_pkg::dmem_aw-1:0];  // word address, upper bits dropped
  assign mem_wdata = rs2_val;  // sw stores rs2
  assign is_load = (op == cpu_pkg::op_lw);
  assign wr_data = is_load ? mem_rdata : sum;

  // single cycle, in order, so a pop retires the head
  assign pop_en = !empty && !halted;

  always_comb begin
    wr_en    = 1'b0;
    mem_we   = 1'b0;
    halt_now = 1'b0;
    if (pop_en) begin
      case (op)
        cpu_pkg::op_addi,
        cpu_pkg::op_add,
        cpu_pkg::op_lw:   wr_en = 1'b1;  // write back to rd
        cpu_pkg::op_sw:   mem_we = 1'b1;  // store
        cpu_pkg::op_halt: halt_now = 1'b1;
        default:          ;  // unknown opcode retires as a no-op
      endcase
    end
  end

  // sticky until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (halt_now) begin
      halted <= 1'b1;
    end
  end

  // a retiring instruction writes either the register file or memory, never both
  a_one_writer: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(mem_we && wr_en)
  ) else $error("register and memory write in the same cycle");

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`default_nettype none

module fetch_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  // program load, used while reset is held
  input  logic                        prog_we,
  input  logic [cpu_pkg::imem_aw-1:0] prog_addr,
  input  logic [cpu_pkg::xlen-1:0]    prog_data,
  // queue side
  input  logic                        full,
  output logic                        push_en,
  output logic [cpu_pkg::xlen-1:0]    push_word
);

  logic [cpu_pkg::xlen-1:0]    rom [cpu_pkg::imem_depth];  // program store, no reset
  logic [cpu_pkg::imem_aw-1:0] pc;  // word address of next fetch
  logic                        done;  // halt already pushed
  logic                        is_halt;  // word at pc is a halt

  // loader port, one word per cycle
  always_ff @(posedge clk) begin
    if (prog_we) begin
      rom[prog_addr] <= prog_data;
    end
  end

  assign push_word = rom[pc];  // combinational rom read at pc
  assign is_halt = (push_word[cpu_pkg::op_lsb +: cpu_pkg::op_w] == cpu_pkg::op_halt);

  // keep pushing until halt has gone out, stall on full
  assign push_en = !done && !full;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc   <= '0;  // restart at word 0
      done <= 1'b0;
    end else if (push_en) begin
      pc <= pc + 1'b1;  // advance only on an accepted push
      if (is_halt) begin
        done <= 1'b1;  // words after halt never leave fetch
      end
    end
  end

  // once halt is out the pc is frozen until the next reset
  a_pc_frozen: assert property (
    @(posedge clk) disable iff (!rst_n)
    done |=> $stable(pc) && done
  ) else $error("fetch pc moved after halt was pushed");

endmodule

`default_nettype wire

// ==== design/inst_queue.sv ====
`default_nettype none

module inst_queue (
  input  logic                     clk,
  input  logic                     rst_n,
  // producer side
  input  logic                     push_en,
  input  logic [cpu_pkg::xlen-1:0] push_word,
  output logic                     full,
  // consumer side, show-ahead
  input  logic                     pop_en,
  output logic [cpu_pkg::xlen-1:0] head_word,
  output logic                     empty
);

  logic [cpu_pkg::xlen-1:0]     mem [cpu_pkg::queue_depth];  // entry storage
  logic [cpu_pkg::queue_aw-1:0] rd_ptr;  // head entry
  logic [cpu_pkg::queue_aw-1:0] wr_ptr;  // next free slot
  logic [cpu_pkg::queue_aw:0]   count;  // occupancy, one extra bit for full

  // storage write, payload only
  always_ff @(posedge clk) begin
    if (push_en) begin
      mem[wr_ptr] <= push_word;
    end
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   count <= count + 1'b1;  // push only
        2'b01:   count <= count - 1'b1;  // pop only
        default: count <= count;  // idle, or push and pop together
      endcase
    end
  end

  assign head_word = mem[rd_ptr];  // valid whenever empty is low
  assign empty = (count == '0);
  assign full = (count == (cpu_pkg::queue_aw + 1)'(cpu_pkg::queue_depth));

  // fetch must honour full
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    full |-> !push_en
  ) else $error("push while queue full");

  // execute must honour empty
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    empty |-> !pop_en
  ) else $error("pop while queue empty");

  // a word pushed into an empty queue is at the head next cycle
  a_show_ahead: assert property (
    @(posedge clk) disable iff (!rst_n)
    (empty && push_en) |=> (!empty && head_word == $past(push_word))
  ) else $error("pushed word not at head one cycle later");

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

module reg_file (
  input  logic                       clk,
  input  logic                       rst_n,
  // execute read ports
  input  logic [cpu_pkg::reg_aw-1:0] rs1_idx,
  input  logic [cpu_pkg::reg_aw-1:0] rs2_idx,
  output logic [cpu_pkg::xlen-1:0]   rs1_val,
  output logic [cpu_pkg::xlen-1:0]   rs2_val,
  // write port
  input  logic                       wr_en,
  input  logic [cpu_pkg::reg_aw-1:0] wr_idx,
  input  logic [cpu_pkg::xlen-1:0]   wr_data,
  // debug read port
  input  logic [cpu_pkg::reg_aw-1:0] dbg_reg_idx,
  output logic [cpu_pkg::xlen-1:0]   dbg_reg_data
);

  logic [cpu_pkg::xlen-1:0] regs [cpu_pkg::num_regs];  // architectural registers

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < cpu_pkg::num_regs; i++) begin
        regs[i] <= '0;  // whole file cleared
      end
    end else if (wr_en && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;  // writes to x0 dropped
    end
  end

  // x0 reads zero on every port
  assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];
  assign dbg_reg_data = (dbg_reg_idx == '0) ? '0 : regs[dbg_reg_idx];

  // a write shows up on the debug port one cycle later
  a_wr_visible: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wr_en && wr_idx != '0) ##1 (dbg_reg_idx == $past(wr_idx))
      |-> dbg_reg_data == $past(wr_data)
  ) else $error("register write not visible on debug port");

endmodule

`default_nettype wire

// ==== flist.f ====
design/cpu_pkg.sv
design/fetch_unit.sv
design/inst_queue.sv
design/exec_unit.sv
design/reg_file.sv
design/data_ram.sv
design/cpu_top.sv
verification/cpu_tb.sv

// ==== verification/cpu_tb.sv ====
`default_nettype none

module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 40;
  localparam int num_random = 6;  // random programs after the three directed ones
  localparam int num_progs = 3 + num_random;
  localparam int rand_len = 20;  // random instructions before the closing halt
  localparam int sweep_n = 16;  // all registers, and every data word the programs touch

  logic                        clk;
  logic                        rst_n;
  logic                        prog_we;
  logic [cpu_pkg::imem_aw-1:0] prog_addr;
  logic [cpu_pkg::xlen-1:0]    prog_data;
  logic [cpu_pkg::reg_aw-1:0]  dbg_reg_idx;
  logic [cpu_pkg::xlen-1:0]    dbg_reg_data;
  logic [cpu_pkg::dmem_aw-1:0] dbg_mem_addr;
  logic [cpu_pkg::xlen-1:0]    dbg_mem_data;
  logic                        halted;

  logic [cpu_pkg::xlen-1:0] prog [cpu_pkg::imem_depth];  // program under test
  int                       prog_len;
  logic [cpu_pkg::xlen-1:0] exp_regs [cpu_pkg::num_regs];  // expected registers
  logic [cpu_pkg::xlen-1:0] exp_mem [cpu_pkg::dmem_depth];  // survives between programs, like the ram
  bit                       exp_valid [cpu_pkg::dmem_depth];  // word written at least once
  bit                       gen_written [sweep_n];  // store targets the generator has used
  integer                   seed;
  event                     check_req;
  event                     check_ack;

  cpu_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .dbg_reg_idx  (dbg_reg_idx),
    .dbg_reg_data (dbg_reg_data),
    .dbg_mem_addr (dbg_mem_addr),
    .dbg_mem_data (dbg_mem_data),
    .halted       (halted)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [cpu_pkg::xlen-1:0] encode(
    input int imm, input int rs2, input int rs1, input int rd, input int opt,
    input logic [cpu_pkg::op_w-1:0] op
  );
    logic [cpu_pkg::xlen-1:0] w;
    w = '0;
    w[cpu_pkg::imm_lsb +: cpu_pkg::imm_w] = imm[cpu_pkg::imm_w-1:0];  // low 12 bits, two's complement
    w[cpu_pkg::rs2_lsb +: 4] = rs2[3:0];
    w[cpu_pkg::rs1_lsb +: 4] = rs1[3:0];
    w[cpu_pkg::rd_lsb +: 4] = rd[3:0];
    w[7:4] = opt[3:0];  // reserved field
    w[cpu_pkg::op_lsb +: cpu_pkg::op_w] = op;
    return w;
  endfunction

  function automatic void emit(input logic [cpu_pkg::xlen-1:0] w);
    prog[prog_len] = w;
    prog_len++;
  endfunction

  // interprets prog[] in order until halt
  function automatic void model_run();
    logic [cpu_pkg::xlen-1:0] w;
    logic [cpu_pkg::xlen-1:0] a;
    logic [cpu_pkg::xlen-1:0] b;
    logic [cpu_pkg::xlen-1:0] imm;
    logic [cpu_pkg::xlen-1:0] sum;
    int op;
    int rd;
    int addr;
    for (int r = 0; r < cpu_pkg::num_regs; r++) begin
      exp_regs[r] = '0;  // reset clears the file
    end
    for (int pc = 0; pc < prog_len; pc++) begin
      w = prog[pc];
      op = w & 32'hf;
      rd = (w >> cpu_pkg::rd_lsb) & 32'hf;
      a = exp_regs[(w >> cpu_pkg::rs1_lsb) & 32'hf];  // x0 stays zero in the model
      b = exp_regs[(w >> cpu_pkg::rs2_lsb) & 32'hf];
      imm = w >> cpu_pkg::imm_lsb;
      if (imm[11]) begin
        imm = imm | 32'hffff_f000;  // sign extend
      end
      sum = (op == 1) ? a + b : a + imm;
      addr = sum & (cpu_pkg::dmem_depth - 1);  // word address from the low bits
      case (op)
        0, 1: if (rd != 0) exp_regs[rd] = sum;
        4: if (rd != 0) exp_regs[rd] = exp_mem[addr];
        5: begin
          exp_mem[addr] = b;
          exp_valid[addr] = 1'b1;
        end
        10: return;  // halt, later words never run
        default: ;  // no-op
      endcase
    end
  endfunction

  task automatic check_eq(input logic [cpu_pkg::xlen-1:0] got,
                          input logic [cpu_pkg::xlen-1:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // one debug read, driven on the rising edge and sampled on the falling edge
  task automatic probe(input int ridx, input int maddr,
                       output logic [cpu_pkg::xlen-1:0] rval,
                       output logic [cpu_pkg::xlen-1:0] mval);
    @(posedge clk);
    dbg_reg_idx <= ridx[cpu_pkg::reg_aw-1:0];
    dbg_mem_addr <= maddr[cpu_pkg::dmem_aw-1:0];
    @(negedge clk);
    rval = dbg_reg_data;
    mval = dbg_mem_data;
  endtask

  // load under reset, release, wait for halt, then hand over to the compare process
  task automatic run_program();
    model_run();
    @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      prog_we <= 1'b1;
      prog_addr <= i[cpu_pkg::imem_aw-1:0];
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    repeat (5) @(posedge clk);  // five more reset cycles after the last word
    rst_n <= 1'b1;
    do @(negedge clk); while (!halted);  // watchdog covers a missing halt
    -> check_req;
    @(check_ack);
  endtask

  task automatic gen_random();
    int kind;
    int rd;
    int rs1;
    int rs2;
    int imm;
    int opt;
    int addr;
    prog_len = 0;
    for (int i = 0; i < rand_len; i++) begin
      kind = $unsigned($random(seed)) % 5;
      rd = $unsigned($random(seed)) % 16;
      rs1 = $unsigned($random(seed)) % 16;
      rs2 = $unsigned($random(seed)) % 16;
      imm = $random(seed);  // any 12 bit value, negatives too
      opt = $unsigned($random(seed)) % 16;  // reserved bits must be ignored
      addr = $unsigned($random(seed)) % sweep_n;
      if (kind == 3 && !gen_written[addr]) begin
        kind = 2;  // load only from a word that holds data
      end
      case (kind)
        0: emit(encode(imm, rs2, rs1, rd, opt, cpu_pkg::op_addi));
        1: emit(encode(imm, rs2, rs1, rd, opt, cpu_pkg::op_add));
        2: begin
          emit(encode(addr, rs2, 0, rd, opt, cpu_pkg::op_sw));  // base x0
          gen_written[addr] = 1'b1;
        end
        3: emit(encode(addr, rs2, 0, rd, opt, cpu_pkg::op_lw));
        default: emit(encode(imm, rs2, rs1, rd, opt, 4'hc));  // unused opcode
      endcase
    end
    emit(encode(0, 0, 0, 0, 0, cpu_pkg::op_halt));
  endtask

  // full sweep of registers and written words against the model
  always begin : compare
    logic [cpu_pkg::xlen-1:0] rval;
    logic [cpu_pkg::xlen-1:0] mval;
    @(check_req);
    for (int i = 0; i < sweep_n; i++) begin
      probe(i, i, rval, mval);
      check_eq(rval, exp_regs[i], $sformatf("register x%0d", i));
      if (exp_valid[i]) begin
        check_eq(mval, exp_mem[i], $sformatf("memory word %0d", i));
      end
    end
    -> check_ack;
  end

  initial begin : watchdog
    #(num_progs * (cpu_pkg::imem_depth + 20) * clk_period);
    $display("ERROR: timeout, halted never rose within the expected run time");
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [cpu_pkg::xlen-1:0] rval;
    logic [cpu_pkg::xlen-1:0] mval;
    clk = 1'b0;
    rst_n = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    dbg_reg_idx = '0;
    dbg_mem_addr = '0;
    seed = 46;
    for (int a = 0; a < cpu_pkg::dmem_depth; a++) begin
      exp_mem[a] = 'x;  // ram is never cleared
      exp_valid[a] = 1'b0;
    end
    for (int a = 0; a < sweep_n; a++) begin
      gen_written[a] = 1'b0;
    end

    // addi from x0
    prog_len = 0;
    emit(encode(1, 0, 0, 1, 0, cpu_pkg::op_addi));  // x1 = x0 + 1
    emit(encode(0, 0, 0, 0, 0, cpu_pkg::op_halt));
    run_program();
    probe(1, 0, rval, mval);
    check_eq(rval, 32'd1, "x1 after addi from x0");

    // dependent arithmetic, store, load, negative offset
    prog_len = 0;
    emit(encode(3, 0, 0, 2, 0, cpu_pkg::op_addi));  // x2 = 3
    emit(encode(1, 0, 2, 3, 0, cpu_pkg::op_addi));  // x3 = x2 + 1
    emit(encode(0, 2, 3, 4, 0, cpu_pkg::op_add));  // x4 = x3 + x2 = 7
    emit(encode(0, 4, 2, 0, 0, cpu_pkg::op_sw));  // mem[x2] = x4
    emit(encode(0, 0, 2, 5, 0, cpu_pkg::op_lw));  // x5 = mem[x2]
    emit(encode(4, 0, 0, 6, 0, cpu_pkg::op_addi));  // x6 = 4
    emit(encode(-1, 0, 6, 7, 0, cpu_pkg::op_lw));  // x7 = mem[x6 - 1]
    emit(encode(0, 0, 0, 0, 0, cpu_pkg::op_halt));
    run_program();
    probe(4, 3, rval, mval);
    check_eq(rval, 32'd7, "x4 after add");
    check_eq(mval, 32'd7, "memory word 3 after sw");
    probe(5, 3, rval, mval);
    check_eq(rval, 32'd7, "x5 after lw");
    probe(7, 3, rval, mval);
    check_eq(rval, 32'd7, "x7 after lw with negative offset");

    // x0 stays zero, nothing after halt runs
    prog_len = 0;
    emit(encode(5, 0, 0, 0, 0, cpu_pkg::op_addi));  // x0 = 5, dropped
    emit(encode(9, 0, 0, 1, 0, cpu_pkg::op_addi));  // x1 = 9
    emit(encode(0, 1, 1, 0, 0, cpu_pkg::op_add));  // x0 = x1 + x1, dropped
    emit(encode(10, 1, 0, 0, 0, cpu_pkg::op_sw));  // mem[10] = 9
    emit(encode(0, 0, 0, 0, 0, cpu_pkg::op_halt));
    emit(encode(100, 0, 0, 1, 0, cpu_pkg::op_addi));  // past halt
    emit(encode(10, 1, 0, 0, 0, cpu_pkg::op_sw));  // past halt
    emit(encode(55, 0, 0, 2, 0, cpu_pkg::op_addi));  // past halt
    run_program();
    probe(0, 10, rval, mval);
    check_eq(rval, 32'd0, "x0 after writes to x0");
    check_eq(mval, 32'd9, "memory word 10 after halt");
    probe(1, 10, rval, mval);
    check_eq(rval, 32'd9, "x1 after halt");
    probe(2, 10, rval, mval);
    check_eq(rval, 32'd0, "x2 after halt");
    repeat (10) begin
      @(negedge clk);
      check_eq(halted, 32'd1, "halted held after halt");
    end

    for (int p = 0; p < num_random; p++) begin
      gen_random();
      run_program();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
